// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module dlm_tb -Mdir obj_dir
	./obj_dir/Vdlm_tb | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+src
src/dlm_pkg.sv
src/dlm_ecc_enc.sv
src/dlm_ecc_ram.sv
src/dlm_ecc_dec.sv
src/dlm_err_log.sv
src/dlm_top.sv
test/dlm_tb.sv

// ==== src/dlm_config.svh ====
// widths for the DLM ECC slice, included by the package and every RTL module that sizes a port
`ifndef DLM_CONFIG_SVH
`define DLM_CONFIG_SVH

// ####################
// memory geometry
// ####################

// word address width, 2048 words
`define DLM_AW 11

// store word
`define DLM_DATA_W 32

// hamming bits plus one overall parity bit
`define DLM_CHK_W 7

// stored codeword, check field on top of data
`define DLM_CW_W (`DLM_DATA_W + `DLM_CHK_W)

// syndrome excludes the overall parity bit
`define DLM_SYN_W (`DLM_CHK_W - 1)

// ####################
// error log
// ####################

// corrected-error counter, saturates at all ones
`define DLM_ERR_CNT_W 8

`endif

// ==== src/dlm_ecc_dec.sv ====
// SECDED decoder on the DLM read path, corrects one flipped bit and flags two
`timescale 1ns/1ps
`include "dlm_config.svh"

module dlm_ecc_dec import dlm_pkg::*; (
	input  dlm_cw_u                rd_cw,
	output logic [`DLM_DATA_W-1:0] rdata,
	output logic                   sec_err,
	output logic                   ded_err
);

	logic [`DLM_SYN_W-1:0] syn;  // points at the flipped bit
	logic                  par;  // odd = odd number of flips
	logic                  hit;  // syndrome matches a real column
	dlm_cw_u               fix;  // corrected codeword

	// ####################
	// syndrome
	// ####################

	always_comb begin
		syn = '0;
		for (int k = 0; k < `DLM_CW_W - 1; k++) begin
			syn ^= col_code(k) & {`DLM_SYN_W{rd_cw.raw[k]}};
		end
		par = ^rd_cw.raw; // includes the overall parity bit
	end

	// ####################
	// correction
	// ####################

	// flip back only on a single error; a double passes through untouched
	always_comb begin
		fix = rd_cw;
		hit = 1'b0;
		for (int k = 0; k < `DLM_CW_W - 1; k++) begin
			if (syn == col_code(k)) begin
				hit = 1'b1;
				if (par)
					fix.raw[k] = ~rd_cw.raw[k];
			end
		end
	end

	assign rdata = fix.f.data;

	// ####################
	// error flags
	// ####################

	// syndrome 0 with odd parity: the overall parity bit itself flipped
	// syndrome beyond position 38 with odd parity cannot be a single error
	always_comb begin
		sec_err = par && ((syn == '0) || hit);
		ded_err = (syn != '0) && !(par && hit);
		a_flags_excl: assert (!(sec_err && ded_err))
			else $error("dlm_ecc_dec: sec_err and ded_err both set");
	end

endmodule

// ==== src/dlm_ecc_enc.sv ====
// SECDED encoder for DLM stores, with a codeword bit-flip mask for ECC test mode
`timescale 1ns/1ps
`include "dlm_config.svh"

module dlm_ecc_enc import dlm_pkg::*; (
	input  logic [`DLM_DATA_W-1:0] wdata,
	input  logic [`DLM_CW_W-1:0]   inj_mask, // 1 = flip that codeword bit
	output dlm_cw_u                wr_cw
);

	logic [`DLM_SYN_W-1:0] ham;  // hamming check bits
	logic                  ovp;  // overall parity
	dlm_cw_u               cw;   // clean codeword

	// ####################
	// check bit generation
	// ####################

	// each data bit feeds the check bits set in its column
	always_comb begin
		ham = '0;
		for (int i = 0; i < `DLM_DATA_W; i++) begin
			ham ^= col_code(i) & {`DLM_SYN_W{wdata[i]}};
		end
	end

	// even parity over data and hamming bits together
	assign ovp = ^{wdata, ham};

	always_comb begin
		cw.f.data = wdata;
		cw.f.chk  = {ovp, ham};
	end

	// ####################
	// fault injection
	// ####################

	// zero mask in normal operation
	assign wr_cw.raw = cw.raw ^ inj_mask;

endmodule

// ==== src/dlm_ecc_ram.sv ====
// single-port 39-bit DLM array with registered read, standing in for the SRAM macro
`timescale 1ns/1ps
`include "dlm_config.svh"

module dlm_ecc_ram import dlm_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cs,
	input  logic              we,
	input  logic [`DLM_AW-1:0] addr,
	input  dlm_cw_u           wr_cw,
	output dlm_cw_u           rd_cw,
	output logic              rd_valid,
	output logic [`DLM_AW-1:0] rd_addr
);

	dlm_cw_u mem [2**`DLM_AW]; // behavioural macro model

	// ####################
	// array port
	// ####################

	always_ff @(posedge clk) begin
		if (cs && we)
			mem[addr] <= wr_cw;
		else if (cs)
			rd_cw <= mem[addr]; // data out one cycle after the access
	end

	// address travels with the read data for the error log
	always_ff @(posedge clk) begin
		if (cs && !we)
			rd_addr <= addr;
	end

	// one-cycle pulse per accepted read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= cs && !we;
	end

	// an unknown address would corrupt or read an undefined word
	a_addr_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		cs |-> !$isunknown(addr)
	);

endmodule

// ==== src/dlm_err_log.sv ====
// DLM ECC error log: corrected-read count, first error address and sticky double-error flag
`timescale 1ns/1ps
`include "dlm_config.svh"

module dlm_err_log (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      rd_valid,
	input  logic                      sec_err,
	input  logic                      ded_err,
	input  logic [`DLM_AW-1:0]        rd_addr,
	input  logic                      err_clr,
	output logic [`DLM_ERR_CNT_W-1:0] err_cnt,
	output logic [`DLM_AW-1:0]        err_addr,
	output logic                      err_addr_valid,
	output logic                      ded_sticky
);

	logic any_err;

	assign any_err = rd_valid && (sec_err || ded_err);

	// ####################
	// log registers
	// ####################

	// clear wins over an event in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_cnt        <= '0;
			err_addr       <= '0;
			err_addr_valid <= 1'b0;
			ded_sticky     <= 1'b0;
		end else if (err_clr) begin
			err_cnt        <= '0;
			err_addr       <= '0;
			err_addr_valid <= 1'b0;
			ded_sticky     <= 1'b0;
		end else begin
			if (rd_valid && sec_err && !(&err_cnt))
				err_cnt <= err_cnt + 1'b1; // saturate at all ones
			if (any_err && !err_addr_valid) begin
				err_addr       <= rd_addr; // first error only
				err_addr_valid <= 1'b1;
			end
			if (rd_valid && ded_err)
				ded_sticky <= 1'b1;
		end
	end

	// only err_clr may take a full counter back down
	a_cnt_sat: assert property (
		@(posedge clk) disable iff (!rst_n)
		(&err_cnt && !err_clr) |=> &err_cnt
	);

endmodule

// ==== src/dlm_pkg.sv ====
// codeword type and H-matrix column lookup shared by the DLM encoder, RAM and decoder
`include "dlm_config.svh"

package dlm_pkg;

	// one stored word, seen flat or as check/data fields
	typedef union packed {
		logic [`DLM_CW_W-1:0] raw;
		struct packed {
			logic [`DLM_CHK_W-1:0]  chk; // [6] overall parity, [5:0] hamming
			logic [`DLM_DATA_W-1:0] data;
		} f;
	} dlm_cw_u;

	// H-matrix column for raw bit k (k below the overall parity bit)
	// data bits take the non power of two positions 3,5,6,7,9..38
	function automatic logic [`DLM_SYN_W-1:0] col_code(input int k);
		logic [`DLM_SYN_W-1:0] code;
		int n;
		code = '0;
		n = 0;
		if (k >= `DLM_DATA_W) begin
			code[k - `DLM_DATA_W] = 1'b1; // check bit, one-hot column
		end else begin
			for (int p = 3; p < `DLM_CW_W; p++) begin
				if ((p & (p - 1)) != 0) begin
					if (n == k)
						code = p[`DLM_SYN_W-1:0];
					n++;
				end
			end
		end
		return code;
	endfunction

endpackage

// ==== src/dlm_top.sv ====
// DLM slice top: SECDED encoder, RAM, decoder and error log on plain cs/we strobes
`timescale 1ns/1ps
`include "dlm_config.svh"

module dlm_top import dlm_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      dlm_cs,
	input  logic                      dlm_we,
	input  logic [`DLM_AW-1:0]        dlm_addr,
	input  logic [`DLM_DATA_W-1:0]    dlm_wdata,
	input  logic [`DLM_CW_W-1:0]      inj_mask,
	input  logic                      err_clr,
	output logic [`DLM_DATA_W-1:0]    dlm_rdata,
	output logic                      dlm_rvalid,
	output logic                      sec_err,
	output logic                      ded_err,
	output logic [`DLM_ERR_CNT_W-1:0] err_cnt,
	output logic [`DLM_AW-1:0]        err_addr,
	output logic                      err_addr_valid,
	output logic                      ded_sticky
);

	dlm_cw_u                wr_cw;
	dlm_cw_u                rd_cw;
	logic                   rd_valid;
	logic [`DLM_AW-1:0]     rd_addr;
	logic [`DLM_DATA_W-1:0] dec_rdata;
	logic                   dec_sec;
	logic                   dec_ded;

	dlm_ecc_enc enc_i (.wdata(dlm_wdata), .inj_mask(inj_mask), .wr_cw(wr_cw));

	dlm_ecc_ram ram_i (
		.clk(clk), .rst_n(rst_n), .cs(dlm_cs), .we(dlm_we), .addr(dlm_addr),
		.wr_cw(wr_cw), .rd_cw(rd_cw), .rd_valid(rd_valid), .rd_addr(rd_addr)
	);

	dlm_ecc_dec dec_i (.rd_cw(rd_cw), .rdata(dec_rdata), .sec_err(dec_sec), .ded_err(dec_ded));

	// decoder output only means something in the read-valid cycle
	assign dlm_rdata  = dec_rdata & {`DLM_DATA_W{rd_valid}};
	assign sec_err    = dec_sec & rd_valid;
	assign ded_err    = dec_ded & rd_valid;
	assign dlm_rvalid = rd_valid;

	dlm_err_log log_i (
		.clk(clk), .rst_n(rst_n), .rd_valid(rd_valid), .sec_err(sec_err),
		.ded_err(ded_err), .rd_addr(rd_addr), .err_clr(err_clr), .err_cnt(err_cnt),
		.err_addr(err_addr), .err_addr_valid(err_addr_valid), .ded_sticky(ded_sticky)
	);

endmodule

// ==== test/dlm_tb.sv ====
// directed testbench for the DLM ECC slice run as top module dlm_tb through all.f
`timescale 1ns/1ps
`include "dlm_config.svh"

module dlm_tb;

	localparam int NUM_WORDS  = 16;
	localparam int RD_TIMEOUT = 16; // cycles to wait for a read-valid pulse

	logic                      clk;
	logic                      rst_n;
	logic                      dlm_cs;
	logic                      dlm_we;
	logic [`DLM_AW-1:0]        dlm_addr;
	logic [`DLM_DATA_W-1:0]    dlm_wdata;
	logic [`DLM_CW_W-1:0]      inj_mask;
	logic                      err_clr;
	logic [`DLM_DATA_W-1:0]    dlm_rdata;
	logic                      dlm_rvalid;
	logic                      sec_err;
	logic                      ded_err;
	logic [`DLM_ERR_CNT_W-1:0] err_cnt;
	logic [`DLM_AW-1:0]        err_addr;
	logic                      err_addr_valid;
	logic                      ded_sticky;

	int errors   = 0;
	int timeouts = 0;
	logic [31:0] rng_state = 32'd73760;

	logic [`DLM_DATA_W-1:0] model [2**`DLM_AW]; // expected array contents
	logic [`DLM_AW-1:0]     addrs [NUM_WORDS];

	dlm_top dlm_top_i (.*);

	always #2 clk = ~clk;

	// ####################
	// helpers
	// ####################

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// called and returns on a falling edge
	task automatic write_word(input logic [`DLM_AW-1:0] addr, input logic [31:0] data,
			input logic [`DLM_CW_W-1:0] mask);
		dlm_cs    = 1'b1;
		dlm_we    = 1'b1;
		dlm_addr  = addr;
		dlm_wdata = data;
		inj_mask  = mask;
		@(negedge clk);
		dlm_cs   = 1'b0;
		dlm_we   = 1'b0;
		inj_mask = '0;
		model[addr] = data;
	endtask

	// returns in the read-valid cycle with results sampled there
	task automatic read_word(input logic [`DLM_AW-1:0] addr, output logic [31:0] data,
			output logic sec, output logic ded);
		int n;
		dlm_cs   = 1'b1;
		dlm_we   = 1'b0;
		dlm_addr = addr;
		@(negedge clk);
		dlm_cs = 1'b0;
		n = 0;
		while (!dlm_rvalid && n < RD_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!dlm_rvalid) begin
			timeouts++;
			$display("timeout: read of address %0h got no read-valid pulse in %0d cycles",
				addr, RD_TIMEOUT);
		end
		data = dlm_rdata;
		sec  = sec_err;
		ded  = ded_err;
	endtask

	task automatic pulse_clear();
		err_clr = 1'b1;
		@(negedge clk);
		err_clr = 1'b0;
	endtask

	// ####################
	// directed tests
	// ####################

	task automatic clean_write_read();
		logic [31:0] r;
		logic [31:0] d;
		logic        s;
		logic        e;
		for (int i = 0; i < NUM_WORDS; i++) begin
			r = next_rand();
			addrs[i] = r[`DLM_AW+7:8];
			write_word(addrs[i], next_rand(), '0);
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			read_word(addrs[i], d, s, e);
			check_eq(d, model[addrs[i]], "clean read data");
			check_eq(s, 0, "clean read sec_err");
			check_eq(e, 0, "clean read ded_err");
		end
		// write then read of the same word on the next cycle
		write_word(addrs[0], next_rand(), '0);
		read_word(addrs[0], d, s, e);
		check_eq(d, model[addrs[0]], "read right after write");
	endtask

	task automatic back_to_back_reads();
		for (int i = 0; i < NUM_WORDS; i++) begin
			dlm_cs   = 1'b1;
			dlm_we   = 1'b0;
			dlm_addr = addrs[i];
			@(negedge clk); // result of read i is out now
			check_eq(dlm_rvalid, 1, "burst rvalid");
			check_eq(dlm_rdata, model[addrs[i]], "burst data in order");
			check_eq(sec_err | ded_err, 0, "burst error flags");
		end
		dlm_cs = 1'b0;
		@(negedge clk);
		check_eq(dlm_rvalid, 0, "rvalid after burst");
	endtask

	task automatic single_bit_inject();
		int                 pos [6] = '{0, 17, 31, 32, 36, 38}; // 38 = overall parity
		logic [`DLM_AW-1:0] a;
		logic [`DLM_AW-1:0] first;
		logic [31:0]        w;
		logic [31:0]        d;
		logic               s;
		logic               e;
		pulse_clear();
		for (int i = 0; i < 6; i++) begin
			w = next_rand();
			a = w[`DLM_AW+3:4];
			if (i == 0)
				first = a;
			write_word(a, ~w, `DLM_CW_W'(1) << pos[i]);
			read_word(a, d, s, e);
			check_eq(d, 32'(~w), $sformatf("data after flip of bit %0d", pos[i]));
			check_eq(s, 1, $sformatf("sec_err after flip of bit %0d", pos[i]));
			check_eq(e, 0, $sformatf("ded_err after flip of bit %0d", pos[i]));
		end
		@(negedge clk);
		check_eq(err_cnt, 6, "corrected count");
		check_eq(err_addr_valid, 1, "err_addr_valid after single errors");
		check_eq(err_addr, first, "first single error address");
		check_eq(ded_sticky, 0, "ded_sticky after single errors");
	endtask

	task automatic double_bit_inject();
		int                 lo [3] = '{0, 5, 20};
		int                 hi [3] = '{1, 33, 38};
		logic [`DLM_CW_W-1:0] m;
		logic [`DLM_AW-1:0] a;
		logic [`DLM_AW-1:0] first;
		logic [31:0]        w;
		logic [31:0]        d;
		logic               s;
		logic               e;
		pulse_clear();
		for (int i = 0; i < 3; i++) begin
			w = next_rand();
			a = w[`DLM_AW+11:12];
			if (i == 0)
				first = a;
			m = (`DLM_CW_W'(1) << lo[i]) | (`DLM_CW_W'(1) << hi[i]);
			write_word(a, w, m);
			read_word(a, d, s, e);
			check_eq(e, 1, $sformatf("ded_err for bits %0d,%0d", lo[i], hi[i]));
			check_eq(s, 0, $sformatf("sec_err for bits %0d,%0d", lo[i], hi[i]));
			check_eq(d, w ^ m[31:0], "double error data passed through");
		end
		@(negedge clk);
		check_eq(ded_sticky, 1, "ded_sticky after double errors");
		check_eq(err_addr, first, "first double error address");
		check_eq(err_cnt, 0, "double errors are not counted");
	endtask

	task automatic clear_and_saturate();
		logic [`DLM_AW-1:0] a;
		logic [31:0]        w;
		logic [31:0]        d;
		logic               s;
		logic               e;
		pulse_clear();
		check_eq(err_cnt, 0, "err_cnt after clear");
		check_eq(err_addr, 0, "err_addr after clear");
		check_eq(err_addr_valid, 0, "err_addr_valid after clear");
		check_eq(ded_sticky, 0, "ded_sticky after clear");
		w = next_rand();
		a = w[`DLM_AW-1:0];
		write_word(a, w, `DLM_CW_W'(1) << 9);
		// clear lands in the same cycle as an error read
		read_word(a, d, s, e);
		pulse_clear();
		check_eq(err_cnt, 0, "clear beats same-cycle error");
		check_eq(err_addr_valid, 0, "clear beats first address capture");
		for (int i = 0; i < 260; i++) begin
			read_word(a, d, s, e);
			check_eq(d, w, "corrected data in saturation run");
			check_eq(s, 1, "sec_err in saturation run");
		end
		@(negedge clk);
		check_eq(err_cnt, 255, "err_cnt holds at all ones");
		check_eq(err_addr, a, "err_addr in saturation run");
		check_eq(ded_sticky, 0, "ded_sticky in saturation run");
	endtask

	// ####################
	// main sequence
	// ####################

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		dlm_cs    = 1'b0;
		dlm_we    = 1'b0;
		dlm_addr  = '0;
		dlm_wdata = '0;
		inj_mask  = '0;
		err_clr   = 1'b0;
		// array runs in reset, so write word 0 then keep reading it
		dlm_cs = 1'b1;
		dlm_we = 1'b1;
		repeat (5) @(negedge clk);
		dlm_we = 1'b0;
		repeat (5) @(negedge clk);
		check_eq(dlm_rvalid, 0, "rvalid held low in reset");
		dlm_cs = 1'b0;
		rst_n  = 1'b1;
		@(negedge clk);
		clean_write_read();
		back_to_back_reads();
		single_bit_inject();
		double_bit_inject();
		clear_and_saturate();
		$display("summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
